// File: dv/dcacheChecker.sv
`timescale 1ns/1ps

module dcacheChecker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reqValid_i,
  input  logic              reqWrite_i,
  input  dcachePkg::addrT   reqAddr_i,
  input  dcachePkg::wordT   wrData_i,
  input  dcachePkg::maskT   wrMask_i,
  input  logic              addrOk_o,
  input  logic              dataOk_o,
  input  dcachePkg::wordT   rdData_o,
  input  logic              rdReq_o,
  input  dcachePkg::addrT   rdAddr_o,
  input  logic              rdReady_i,
  input  logic              rdBeatValid_i,
  input  dcachePkg::wordT   rdBeatData_i,
  input  logic              wrReq_o,
  input  dcachePkg::addrT   wrAddr_o,
  input  dcachePkg::lineT   wrLine_o,
  input  logic              wrReady_i,
  output int                valueErrors_o,
  output int                protocolErrors_o
);
  import dcachePkg::*;

  // flat model over the word range the stimulus touches
  wordT modelMem [1024];
  maskT known [1024];
  logic stored [256];
  logic pendWrite [$];
  addrT pendAddr [$];
  logic pendFast [$];
  longint pendCycle [$];
  longint cycle = 0;
  logic resetChecked = 1'b0;
  addrT fillAddr = '0;
  logic [1:0] beatIdx = '0;
  logic prevRdWait = 1'b0;
  logic prevWrWait = 1'b0;
  addrT prevRdAddr;
  addrT prevWrAddr;
  lineT prevWrLine;
  addrT lastDoneAddr;
  logic lastDoneValid = 1'b0;

  initial begin
    valueErrors_o = 0;
    protocolErrors_o = 0;
    for (int i = 0; i < 1024; i++) begin
      known[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      stored[i] = 1'b0;
    end
  end

  task automatic reportValue(input string name, input wordT expVal, input wordT actVal);
    $display("[ERROR] %s: expected %h, actual %h", name, expVal, actVal);
    valueErrors_o++;
  endtask

  task automatic reportProtocol(input string text);
    $display("protocol error at cycle %0d: %s", cycle, text);
    protocolErrors_o++;
  endtask

  // pre-edge values are sampled here, register updates land later in the step
  always @(posedge clk) begin : sample
    logic [9:0] w;
    logic fast;
    logic isWrite;
    addrT doneAddr;
    logic doneFast;
    longint doneCycle;
    if (rst_n) begin
      cycle++;
      if (!resetChecked) begin
        if (!addrOk_o || dataOk_o || rdReq_o || wrReq_o) begin
          reportProtocol("outputs not in their reset state after reset");
        end
        resetChecked = 1'b1;
      end
      // back-pressure holds
      if (prevRdWait && (!rdReq_o || rdAddr_o != prevRdAddr)) begin
        reportProtocol("read request dropped or moved before rdReady_i");
      end
      if (prevWrWait && (!wrReq_o || wrAddr_o != prevWrAddr || wrLine_o != prevWrLine)) begin
        reportProtocol("write request dropped or changed before wrReady_i");
      end
      if (dataOk_o && (rdReq_o || wrReq_o)) begin
        reportProtocol("dataOk_o raised while a memory request is pending");
      end
      if (rdReq_o && rdReady_i) begin
        fillAddr = rdAddr_o;
        beatIdx = '0;
        if (rdAddr_o[4:0] != 5'd0) begin
          reportProtocol("refill address is not line aligned");
        end
        if (pendFast.size() > 0 && pendFast[0]) begin
          reportProtocol("refill issued for a load that should hit");
        end
      end
      // refill beats only fill bytes the model has not seen yet
      if (rdBeatValid_i) begin
        w = {fillAddr[12:5], beatIdx};
        for (int b = 0; b < 8; b++) begin
          if (!known[w][b]) begin
            modelMem[w][b*8 +: 8] = rdBeatData_i[b*8 +: 8];
            known[w][b] = 1'b1;
          end
        end
        beatIdx++;
      end
      if (wrReq_o && wrReady_i) begin
        if (wrAddr_o[4:0] != 5'd0) begin
          reportProtocol("write-back address is not line aligned");
        end
        if (!stored[wrAddr_o[12:5]]) begin
          reportProtocol("clean line written back");
        end
        stored[wrAddr_o[12:5]] = 1'b0;
        for (int k = 0; k < 4; k++) begin
          w = {wrAddr_o[12:5], 2'(k)};
          if (known[w] != 8'hff) begin
            reportProtocol("written-back line holds bytes never fetched or stored");
          end else if (wrLine_o[k*64 +: 64] != modelMem[w]) begin
            reportValue("writeBack", modelMem[w], wrLine_o[k*64 +: 64]);
          end
        end
      end
      // completion before acceptance, both may share an edge
      if (dataOk_o) begin
        if (pendAddr.size() == 0) begin
          reportProtocol("dataOk_o without an outstanding request");
        end else begin
          isWrite = pendWrite.pop_front();
          doneAddr = pendAddr.pop_front();
          doneFast = pendFast.pop_front();
          doneCycle = pendCycle.pop_front();
          w = doneAddr[12:3];
          if (!isWrite) begin
            if (known[w] != 8'hff) begin
              reportProtocol("load returned bytes never fetched or stored");
            end else if (rdData_o != modelMem[w]) begin
              reportValue("loadData", modelMem[w], rdData_o);
            end
          end
          if (doneFast && cycle != doneCycle + 1) begin
            reportProtocol("repeated load did not complete one cycle after acceptance");
          end
          lastDoneAddr = doneAddr;
          lastDoneValid = 1'b1;
        end
      end
      if (reqValid_i && addrOk_o) begin
        fast = !reqWrite_i && lastDoneValid && reqAddr_i == lastDoneAddr &&
               pendAddr.size() == 0;
        pendWrite.push_back(reqWrite_i);
        pendAddr.push_back(reqAddr_i);
        pendFast.push_back(fast);
        pendCycle.push_back(cycle);
        if (reqWrite_i) begin
          w = reqAddr_i[12:3];
          for (int b = 0; b < 8; b++) begin
            if (wrMask_i[b]) begin
              modelMem[w][b*8 +: 8] = wrData_i[b*8 +: 8];
              known[w][b] = 1'b1;
            end
          end
          stored[reqAddr_i[12:5]] = 1'b1;
        end
      end
      prevRdWait = rdReq_o && !rdReady_i;
      prevWrWait = wrReq_o && !wrReady_i;
      prevRdAddr = rdAddr_o;
      prevWrAddr = wrAddr_o;
      prevWrLine = wrLine_o;
    end
  end

endmodule

// File: dv/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;
  import dcachePkg::*;

  localparam int numReqs = 400;
  localparam int waitLimit = 2000;

  logic clk;
  logic rst_n;
  logic reqValid;
  logic reqWrite;
  addrT reqAddr;
  wordT wrData;
  maskT wrMask;
  logic addrOk;
  logic dataOk;
  wordT rdData;
  logic rdReq;
  addrT rdAddr;
  logic rdReady;
  logic rdBeatValid;
  wordT rdBeatData;
  logic rdLast;
  logic wrReq;
  addrT wrAddr;
  lineT wrLine;
  logic wrReady;
  int valueErrors;
  int protocolErrors;
  logic [31:0] lfsrState = 32'h644b;
  // backing memory indexed by byte address 12:3
  wordT backing [1024];

  dcacheTop dcacheTop_inst (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqWrite_i(reqWrite), .reqAddr_i(reqAddr),
    .wrData_i(wrData), .wrMask_i(wrMask),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .rdReq_o(rdReq), .rdAddr_o(rdAddr), .rdReady_i(rdReady),
    .rdBeatValid_i(rdBeatValid), .rdBeatData_i(rdBeatData), .rdLast_i(rdLast),
    .wrReq_o(wrReq), .wrAddr_o(wrAddr), .wrLine_o(wrLine), .wrReady_i(wrReady)
  );

  dcacheChecker dcacheChecker_inst (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqWrite_i(reqWrite), .reqAddr_i(reqAddr),
    .wrData_i(wrData), .wrMask_i(wrMask),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .rdReq_o(rdReq), .rdAddr_o(rdAddr), .rdReady_i(rdReady),
    .rdBeatValid_i(rdBeatValid), .rdBeatData_i(rdBeatData),
    .wrReq_o(wrReq), .wrAddr_o(wrAddr), .wrLine_o(wrLine), .wrReady_i(wrReady),
    .valueErrors_o(valueErrors), .protocolErrors_o(protocolErrors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic nextBit();
    logic lsb;
    lsb = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (lsb) begin
      lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], nextBit()};
    end
    return val;
  endfunction

  task automatic stopOnTimeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  // memory responder with random ready delays and beat gaps
  initial begin : responder
    int idle;
    int delay;
    logic [9:0] base;
    rdReady = 1'b0;
    rdBeatValid = 1'b0;
    rdBeatData = '0;
    rdLast = 1'b0;
    wrReady = 1'b0;
    @(negedge clk);
    idle = 0;
    while (!rst_n) begin
      @(negedge clk);
      idle++;
      if (idle > waitLimit) begin
        stopOnTimeout("reset release");
      end
    end
    forever begin
      idle = 0;
      while (!rdReq && !wrReq) begin
        @(negedge clk);
        idle++;
        if (idle > waitLimit) begin
          stopOnTimeout("a memory request");
        end
      end
      delay = randBits(2);
      repeat (delay) @(negedge clk);
      if (wrReq) begin
        base = {wrAddr[12:5], 2'b00};
        for (int k = 0; k < 4; k++) begin
          backing[base + k] = wrLine[k*64 +: 64];
        end
        wrReady = 1'b1;
        @(negedge clk);
        wrReady = 1'b0;
      end else begin
        base = {rdAddr[12:5], 2'b00};
        rdReady = 1'b1;
        @(negedge clk);
        rdReady = 1'b0;
        for (int k = 0; k < 4; k++) begin
          if (randBits(1)) begin
            @(negedge clk);
          end
          rdBeatValid = 1'b1;
          rdBeatData = backing[base + k];
          rdLast = (k == 3);
          @(negedge clk);
          rdBeatValid = 1'b0;
          rdLast = 1'b0;
        end
      end
    end
  end

  initial begin : stimulus
    int cnt;
    addrT lastAddr;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    wrData = '0;
    wrMask = '0;
    lastAddr = '0;
    // pattern holds the word's own byte address in the low half
    for (int i = 0; i < 1024; i++) begin
      backing[i] = {randBits(32), 19'h0, 10'(i), 3'b000};
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int n = 0; n < numReqs; n++) begin
      if (n > 0 && randBits(2) == 0) begin
        reqWrite = 1'b0;
        reqAddr = lastAddr;
      end else begin
        reqWrite = 1'(randBits(1));
        reqAddr = {19'h0, 2'(randBits(2)), 4'h0, 2'(randBits(2)), 2'(randBits(2)), 3'b000};
        wrMask = maskT'(randBits(8));
        wrData = {randBits(32), randBits(32)};
      end
      lastAddr = reqAddr;
      reqValid = 1'b1;
      cnt = 0;
      while (!addrOk) begin
        @(negedge clk);
        cnt++;
        if (cnt > waitLimit) begin
          stopOnTimeout("request acceptance");
        end
      end
      @(negedge clk);
      reqValid = 1'b0;
      if (n < numReqs - 1 && randBits(1)) begin
        @(negedge clk);
      end
    end
    // any completion seen from here on belongs to the last request
    cnt = 0;
    while (!dataOk) begin
      @(negedge clk);
      cnt++;
      if (cnt > waitLimit) begin
        stopOnTimeout("the last completion");
      end
    end
    repeat (3) @(negedge clk);
    $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
rtl/dcachePkg.sv
rtl/dcacheLineRam.sv
rtl/dcacheTagStore.sv
rtl/dcacheRefillBuffer.sv
rtl/dcacheCtrl.sv
rtl/dcacheTop.sv
dv/dcacheChecker.sv
dv/dcacheTb.sv

// File: rtl/dcacheCtrl.sv
`timescale 1ns/1ps

module dcacheCtrl (
  input  logic                  clk,
  input  logic                  rst_n,
  // pipeline side
  input  logic                  reqValid_i,
  input  logic                  reqWrite_i,
  input  dcachePkg::addrT       reqAddr_i,
  input  dcachePkg::wordT       wrData_i,
  input  dcachePkg::maskT       wrMask_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output dcachePkg::wordT       rdData_o,
  // memory side
  output logic                  rdReq_o,
  output dcachePkg::addrT       rdAddr_o,
  input  logic                  rdReady_i,
  input  logic                  rdLast_i,
  input  logic                  rdBeatValid_i,
  output logic                  wrReq_o,
  output dcachePkg::addrT       wrAddr_o,
  output dcachePkg::lineT       wrLine_o,
  input  logic                  wrReady_i,
  // tag store
  output dcachePkg::indexT      lookupIndex_o,
  output dcachePkg::tagT        lookupTag_o,
  output logic                  fillEn_o,
  output logic                  fillWay_o,
  output dcachePkg::tagT        fillTag_o,
  output logic                  dirtySet_o,
  output logic                  dirtyWay_o,
  output logic                  victimWay_o,
  input  logic                  way0Hit_i,
  input  logic                  way1Hit_i,
  input  dcachePkg::tagT        victimTag_i,
  input  logic                  victimDirty_i,
  // refill buffer
  output logic                  getData_o,
  input  dcachePkg::lineT       refillLine_i,
  // line RAMs
  output logic                  ram0En_o,
  output logic                  ram0We_o,
  output dcachePkg::indexT      ram0Addr_o,
  output dcachePkg::lineT       ram0WrLine_o,
  output dcachePkg::lineMaskT   ram0ByteMask_o,
  output logic                  ram1En_o,
  output logic                  ram1We_o,
  output dcachePkg::indexT      ram1Addr_o,
  output dcachePkg::lineT       ram1WrLine_o,
  output dcachePkg::lineMaskT   ram1ByteMask_o,
  input  dcachePkg::lineT       ramRdLine0_i,
  input  dcachePkg::lineT       ramRdLine1_i
);
  import dcachePkg::*;

  cacheStateT state;
  cacheStateT stateNext;
  addrT reqAddrQ;
  logic reqWriteQ;
  wordT wrDataQ;
  maskT wrMaskQ;
  logic replaceQ;
  logic [lfsrWidth-1:0] lfsr;
  logic accept;
  logic hit;
  logic storeHit;
  logic replacing;
  tagT tagQ;
  indexT indexQ;
  logic [$clog2(wordsPerLine)-1:0] wordSel;
  lineT hitLine;
  lineT storeLine;
  lineMaskT storeMask;
  logic [1:0] wayWe;
  logic [1:0] wayEn;
  indexT ramAddr;
  lineT ramWrLine;
  lineMaskT ramByteMask;

  assign tagQ = reqAddrQ[tagMsb:tagLsb];
  assign indexQ = reqAddrQ[indexMsb:indexLsb];
  assign wordSel = reqAddrQ[offsetMsb -: $clog2(wordsPerLine)];

  assign hit = way0Hit_i || way1Hit_i;
  assign accept = reqValid_i && addrOk_o;
  assign storeHit = (state == stCompare) && hit && reqWriteQ;
  assign replacing = state == stReplace;

  // a store hit leaves a bubble so the next read sees the merged bytes
  always_comb begin
    case (state)
      stIdle: addrOk_o = 1'b1;
      stCompare: addrOk_o = hit && !reqWriteQ;
      default: addrOk_o = 1'b0;
    endcase
  end

  assign dataOk_o = (state == stCompare) && hit;

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (accept) begin
          stateNext = stCompare;
        end
      end
      stCompare: begin
        if (hit) begin
          stateNext = accept ? stCompare : stIdle;
        end else if (victimDirty_i) begin
          stateNext = stWriteBack;
        end else begin
          stateNext = stMiss;
        end
      end
      stWriteBack: begin
        if (wrReady_i) begin
          stateNext = stMiss;
        end
      end
      stMiss: begin
        if (rdReady_i) begin
          stateNext = stGetData;
        end
      end
      stGetData: begin
        if (rdBeatValid_i && rdLast_i) begin
          stateNext = stReplace;
        end
      end
      stReplace: stateNext = stCompare;
      default: stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
      reqAddrQ <= '0;
      reqWriteQ <= 1'b0;
      replaceQ <= 1'b0;
    end else begin
      state <= stateNext;
      replaceQ <= replacing;
      if (accept) begin
        reqAddrQ <= reqAddr_i;
        reqWriteQ <= reqWrite_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wrDataQ <= wrData_i;
      wrMaskQ <= wrMask_i;
    end
  end

  // victim way is lfsr[0], stepped when the refill is written
  // so it stays fixed for the whole miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= lfsrSeed;
    end else if (replacing) begin
      lfsr <= lfsr[0] ? ((lfsr >> 1) ^ lfsrTaps) : (lfsr >> 1);
    end
  end

  assign victimWay_o = lfsr[0];

  // right after a replace the RAM output still holds the old victim
  assign hitLine = replaceQ ? refillLine_i : (way1Hit_i ? ramRdLine1_i : ramRdLine0_i);
  assign rdData_o = hitLine[wordSel*$bits(wordT) +: $bits(wordT)];

  // word copied to every slot and the mask picks the one that is written
  assign storeLine = {wordsPerLine{wrDataQ}};
  assign storeMask = lineMaskT'(wrMaskQ) << (wordSel * $bits(maskT));

  assign wayWe[0] = (storeHit && way0Hit_i) || (replacing && !victimWay_o);
  assign wayWe[1] = (storeHit && way1Hit_i) || (replacing && victimWay_o);
  assign wayEn = wayWe | {2{accept}};
  assign ramAddr = (storeHit || replacing) ? indexQ : reqAddr_i[indexMsb:indexLsb];
  assign ramWrLine = replacing ? refillLine_i : storeLine;
  assign ramByteMask = replacing ? '1 : storeMask;

  assign ram0En_o = wayEn[0];
  assign ram0We_o = wayWe[0];
  assign ram0Addr_o = ramAddr;
  assign ram0WrLine_o = ramWrLine;
  assign ram0ByteMask_o = ramByteMask;
  assign ram1En_o = wayEn[1];
  assign ram1We_o = wayWe[1];
  assign ram1Addr_o = ramAddr;
  assign ram1WrLine_o = ramWrLine;
  assign ram1ByteMask_o = ramByteMask;

  // tag store control
  assign lookupIndex_o = indexQ;
  assign lookupTag_o = tagQ;
  assign fillEn_o = replacing;
  assign fillWay_o = victimWay_o;
  assign fillTag_o = tagQ;
  assign dirtySet_o = storeHit;
  assign dirtyWay_o = way1Hit_i;

  // victim line comes from the read at acceptance
  assign wrReq_o = state == stWriteBack;
  assign wrAddr_o = {victimTag_i, indexQ, {(offsetMsb - offsetLsb + 1){1'b0}}};
  assign wrLine_o = victimWay_o ? ramRdLine1_i : ramRdLine0_i;
  assign rdReq_o = state == stMiss;
  assign rdAddr_o = {tagQ, indexQ, {(offsetMsb - offsetLsb + 1){1'b0}}};
  assign getData_o = state == stGetData;

  // the freshly written line must hit on the following compare
  hitAfterReplace: assert property (@(posedge clk) disable iff (!rst_n)
    replacing |=> dataOk_o);

  // victim address and data hold while the memory stalls
  wrReqHeld: assert property (@(posedge clk) disable iff (!rst_n)
    wrReq_o && !wrReady_i |=> wrReq_o && $stable(wrAddr_o) && $stable(wrLine_o));

endmodule

// File: rtl/dcacheLineRam.sv
`timescale 1ns/1ps

module dcacheLineRam (
  input  logic                  clk,
  input  logic                  en_i,
  input  logic                  we_i,
  input  dcachePkg::indexT      addr_i,
  input  dcachePkg::lineT       wrLine_i,
  input  dcachePkg::lineMaskT   wrByteMask_i,
  output dcachePkg::lineT       rdLine_o
);
  import dcachePkg::*;

  lineT mem [numSets];

  // write and read share the port, a write cycle returns the old line
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < lineBytes; b++) begin
          if (wrByteMask_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wrLine_i[b*8 +: 8];
          end
        end
      end
      rdLine_o <= mem[addr_i];
    end
  end

  // controller must never select an undefined set
  addrKnown: assert property (@(posedge clk) en_i |-> !$isunknown(addr_i));

endmodule

// File: rtl/dcachePkg.sv
package dcachePkg;

  // cache geometry, the set count is also the line RAM depth
  localparam int numSets = 64;
  localparam int wordsPerLine = 4;
  localparam int lineBytes = 32;

  // address split
  localparam int tagMsb = 31;
  localparam int tagLsb = 11;
  localparam int indexMsb = 10;
  localparam int indexLsb = 5;
  localparam int offsetMsb = 4;
  localparam int offsetLsb = 0;

  // victim LFSR, x^8 + x^6 + x^5 + x^4 + 1
  localparam int lfsrWidth = 8;
  localparam logic [lfsrWidth-1:0] lfsrSeed = 8'hb5;
  localparam logic [lfsrWidth-1:0] lfsrTaps = 8'hb8;

  typedef logic [31:0] addrT;
  typedef logic [63:0] wordT;
  typedef logic [7:0] maskT;
  typedef logic [255:0] lineT;
  typedef logic [lineBytes-1:0] lineMaskT;
  typedef logic [tagMsb-tagLsb:0] tagT;
  typedef logic [indexMsb-indexLsb:0] indexT;

  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stWriteBack,
    stMiss,
    stGetData,
    stReplace
  } cacheStateT;

endpackage

// File: rtl/dcacheRefillBuffer.sv
`timescale 1ns/1ps

module dcacheRefillBuffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              capture_i,
  input  logic              beatValid_i,
  input  dcachePkg::wordT   beatData_i,
  output dcachePkg::lineT   refillLine_o
);
  import dcachePkg::*;

  logic [$clog2(wordsPerLine)-1:0] beatCnt;
  logic beatTake;

  assign beatTake = capture_i && beatValid_i;

  // wraps to zero after the last beat, ready for the next burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // lowest word arrives first
  always_ff @(posedge clk) begin
    if (beatTake) begin
      refillLine_o[beatCnt*$bits(wordT) +: $bits(wordT)] <= beatData_i;
    end
  end

endmodule

// File: rtl/dcacheTagStore.sv
`timescale 1ns/1ps

module dcacheTagStore (
  input  logic              clk,
  input  logic              rst_n,
  input  dcachePkg::indexT  lookupIndex_i,
  input  dcachePkg::tagT    lookupTag_i,
  input  logic              fillEn_i,
  input  logic              fillWay_i,
  input  dcachePkg::tagT    fillTag_i,
  input  logic              dirtySet_i,
  input  logic              dirtyWay_i,
  input  logic              victimWay_i,
  output logic              way0Hit_o,
  output logic              way1Hit_o,
  output dcachePkg::tagT    victimTag_o,
  output logic              victimDirty_o
);
  import dcachePkg::*;

  tagT tagArr [2][numSets];
  logic [1:0][numSets-1:0] validArr;
  logic [1:0][numSets-1:0] dirtyArr;

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[fillWay_i][lookupIndex_i] <= fillTag_i;
    end
  end

  // a refill brings in a clean line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (fillEn_i) begin
      validArr[fillWay_i][lookupIndex_i] <= 1'b1;
      dirtyArr[fillWay_i][lookupIndex_i] <= 1'b0;
    end else if (dirtySet_i) begin
      dirtyArr[dirtyWay_i][lookupIndex_i] <= 1'b1;
    end
  end

  assign way0Hit_o = validArr[0][lookupIndex_i] &&
                     (tagArr[0][lookupIndex_i] == lookupTag_i);
  assign way1Hit_o = validArr[1][lookupIndex_i] &&
                     (tagArr[1][lookupIndex_i] == lookupTag_i);

  // victim info for the write-back decision and address
  assign victimTag_o = tagArr[victimWay_i][lookupIndex_i];
  assign victimDirty_o = validArr[victimWay_i][lookupIndex_i] &&
                         dirtyArr[victimWay_i][lookupIndex_i];

  // a refill only happens after a miss, so a tag never lands in both ways
  singleWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(way0Hit_o && way1Hit_o));

endmodule

// File: rtl/dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop (
  input  logic              clk,
  input  logic              rst_n,
  // pipeline
  input  logic              reqValid_i,
  input  logic              reqWrite_i,
  input  dcachePkg::addrT   reqAddr_i,
  input  dcachePkg::wordT   wrData_i,
  input  dcachePkg::maskT   wrMask_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output dcachePkg::wordT   rdData_o,
  // memory read
  output logic              rdReq_o,
  output dcachePkg::addrT   rdAddr_o,
  input  logic              rdReady_i,
  input  logic              rdBeatValid_i,
  input  dcachePkg::wordT   rdBeatData_i,
  input  logic              rdLast_i,
  // memory write
  output logic              wrReq_o,
  output dcachePkg::addrT   wrAddr_o,
  output dcachePkg::lineT   wrLine_o,
  input  logic              wrReady_i
);
  import dcachePkg::*;

  indexT lookupIndex;
  tagT lookupTag;
  logic fillEn;
  logic fillWay;
  tagT fillTag;
  logic dirtySet;
  logic dirtyWay;
  logic victimWay;
  logic way0Hit;
  logic way1Hit;
  tagT victimTag;
  logic victimDirty;
  logic getData;
  lineT refillLine;
  logic ram0En;
  logic ram0We;
  indexT ram0Addr;
  lineT ram0WrLine;
  lineMaskT ram0ByteMask;
  logic ram1En;
  logic ram1We;
  indexT ram1Addr;
  lineT ram1WrLine;
  lineMaskT ram1ByteMask;
  lineT ramRdLine0;
  lineT ramRdLine1;

  dcacheCtrl dcacheCtrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid_i),
    .reqWrite_i     (reqWrite_i),
    .reqAddr_i      (reqAddr_i),
    .wrData_i       (wrData_i),
    .wrMask_i       (wrMask_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .rdReq_o        (rdReq_o),
    .rdAddr_o       (rdAddr_o),
    .rdReady_i      (rdReady_i),
    .rdLast_i       (rdLast_i),
    .rdBeatValid_i  (rdBeatValid_i),
    .wrReq_o        (wrReq_o),
    .wrAddr_o       (wrAddr_o),
    .wrLine_o       (wrLine_o),
    .wrReady_i      (wrReady_i),
    .lookupIndex_o  (lookupIndex),
    .lookupTag_o    (lookupTag),
    .fillEn_o       (fillEn),
    .fillWay_o      (fillWay),
    .fillTag_o      (fillTag),
    .dirtySet_o     (dirtySet),
    .dirtyWay_o     (dirtyWay),
    .victimWay_o    (victimWay),
    .way0Hit_i      (way0Hit),
    .way1Hit_i      (way1Hit),
    .victimTag_i    (victimTag),
    .victimDirty_i  (victimDirty),
    .getData_o      (getData),
    .refillLine_i   (refillLine),
    .ram0En_o       (ram0En),
    .ram0We_o       (ram0We),
    .ram0Addr_o     (ram0Addr),
    .ram0WrLine_o   (ram0WrLine),
    .ram0ByteMask_o (ram0ByteMask),
    .ram1En_o       (ram1En),
    .ram1We_o       (ram1We),
    .ram1Addr_o     (ram1Addr),
    .ram1WrLine_o   (ram1WrLine),
    .ram1ByteMask_o (ram1ByteMask),
    .ramRdLine0_i   (ramRdLine0),
    .ramRdLine1_i   (ramRdLine1)
  );

  dcacheTagStore dcacheTagStore_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupIndex_i (lookupIndex),
    .lookupTag_i   (lookupTag),
    .fillEn_i      (fillEn),
    .fillWay_i     (fillWay),
    .fillTag_i     (fillTag),
    .dirtySet_i    (dirtySet),
    .dirtyWay_i    (dirtyWay),
    .victimWay_i   (victimWay),
    .way0Hit_o     (way0Hit),
    .way1Hit_o     (way1Hit),
    .victimTag_o   (victimTag),
    .victimDirty_o (victimDirty)
  );

  // beats come straight from the memory port
  dcacheRefillBuffer dcacheRefillBuffer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .capture_i    (getData),
    .beatValid_i  (rdBeatValid_i),
    .beatData_i   (rdBeatData_i),
    .refillLine_o (refillLine)
  );

  dcacheLineRam way0Ram (
    .clk          (clk),
    .en_i         (ram0En),
    .we_i         (ram0We),
    .addr_i       (ram0Addr),
    .wrLine_i     (ram0WrLine),
    .wrByteMask_i (ram0ByteMask),
    .rdLine_o     (ramRdLine0)
  );

  dcacheLineRam way1Ram (
    .clk          (clk),
    .en_i         (ram1En),
    .we_i         (ram1We),
    .addr_i       (ram1Addr),
    .wrLine_i     (ram1WrLine),
    .wrByteMask_i (ram1ByteMask),
    .rdLine_o     (ramRdLine1)
  );

endmodule
